// ==== flist.f ====
hw/spi_pkg.sv
hw/spi_fifo.sv
hw/spi_master.sv
hw/spi_regs.sv
hw/spi_top.sv
verif/spi_tb.sv

// ==== Bender.yml ====
package:
  name: spi_axi_master

sources:
  - hw/spi_pkg.sv
  - hw/spi_fifo.sv
  - hw/spi_master.sv
  - hw/spi_regs.sv
  - hw/spi_top.sv
  - target: test
    files:
      - verif/spi_tb.sv

// ==== verif/spi_tb.sv ====
`timescale 1ns/1ps

module spi_tb;
    import spi_pkg::*;

    localparam int NCS         = 4;
    localparam int FIFO_DEPTH  = 16;
    localparam int N_FRAMES    = 40;
    localparam int MAX_CHARS   = FIFO_DEPTH;
    localparam int CHAR_CYC    = 2 * CHAR_W * 4 + 4;  // pm 3 plus the byte load
    localparam int BUS_CYC     = 4 * 64 + 60;          // register traffic and the idle window
    localparam int FRAME_CYC   = MAX_CHARS * CHAR_CYC + BUS_CYC;
    localparam int TIMEOUT_CYC = 2 * (N_FRAMES + 2) * FRAME_CYC;

    logic              s_sysclk, s_resetn;
    logic [ADDR_W-1:0] s_awaddr, s_araddr;
    logic [DATA_W-1:0] s_wdata, s_rdata;
    logic [3:0]        s_wstrb;
    logic [1:0]        s_bresp, s_rresp;
    logic              s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
    logic              s_arvalid, s_arready, s_rvalid, s_rready;
    logic              interrupt, spi_sck, spi_mosi;
    logic              spi_miso = 1'b0;
    logic [NCS-1:0]    spi_sel;

    // spi slave model state
    integer            seed = 32'h29642770;
    int                cycle_cnt = 0;
    int                err_cnt = 0;
    logic              armed = 1'b0;
    logic              cur_cpol = 1'b0;
    logic              cur_cpha = 1'b0;
    logic              cur_pol = 1'b0;
    logic              sck_prev = 1'b0;
    logic [NCS-1:0]    sel_exp;
    logic [7:0]        mosi_sr;
    logic [7:0]        miso_byte = 8'h00;
    int                bit_idx = 0;
    int                sck_edges = 0;
    logic [7:0]        tx_exp[$], rx_exp[$], miso_q[$], mosi_seen[$];

    spi_top #(.NCS(NCS), .FIFO_DEPTH(FIFO_DEPTH)) u_spi_top (
        .s_sysclk    (s_sysclk),
        .s_resetn    (s_resetn),
        .s_awaddr_i  (s_awaddr),
        .s_awvalid_i (s_awvalid),
        .s_awready_o (s_awready),
        .s_wdata_i   (s_wdata),
        .s_wstrb_i   (s_wstrb),
        .s_wvalid_i  (s_wvalid),
        .s_wready_o  (s_wready),
        .s_bvalid_o  (s_bvalid),
        .s_bready_i  (s_bready),
        .s_bresp_o   (s_bresp),
        .s_araddr_i  (s_araddr),
        .s_arvalid_i (s_arvalid),
        .s_arready_o (s_arready),
        .s_rdata_o   (s_rdata),
        .s_rvalid_o  (s_rvalid),
        .s_rready_i  (s_rready),
        .s_rresp_o   (s_rresp),
        .interrupt_o (interrupt),
        .spi_sck_o   (spi_sck),
        .spi_mosi_o  (spi_mosi),
        .spi_miso_i  (spi_miso),
        .spi_sel_o   (spi_sel)
    );

    initial begin
        s_sysclk = 1'b0;
        forever #2 s_sysclk = ~s_sysclk;
    end

    always @(posedge s_sysclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYC) begin
            $display("Finished with errors");
            $fatal(1, "timeout: test did not finish within %0d cycles", TIMEOUT_CYC);
        end
    end

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            err_cnt++;
            $display("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("Finished with errors");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // slave reacts to sck mid-cycle, when the master outputs are settled
    always @(negedge s_sysclk) begin
        if (armed && spi_sck != sck_prev) begin
            check_equal(spi_sel, sel_exp, "chip select during frame");
            sck_edges++;
            if (spi_sck != cur_cpol) begin
                if (!cur_cpha) begin
                    mosi_sr = {mosi_sr[6:0], spi_mosi};
                end
            end else begin
                if (cur_cpha) begin
                    mosi_sr = {mosi_sr[6:0], spi_mosi};
                end
                bit_idx++;
                if (bit_idx == 8) begin
                    mosi_seen.push_back(mosi_sr);
                    bit_idx = 0;
                    miso_byte = (miso_q.size() > 0) ? miso_q.pop_front() : 8'h00;
                end
            end
        end
        sck_prev = spi_sck;
        spi_miso = miso_byte[7 - bit_idx]; // next bit changes on the trailing edge
    end

    task automatic axi_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        @(negedge s_sysclk);
        s_awaddr  = addr;
        s_wdata   = data;
        s_wstrb   = strb;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        do @(negedge s_sysclk); while (!s_awready);
        check_equal(s_wready, 1'b1, "wready together with awready");
        @(negedge s_sysclk);
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        check_equal(s_awready, 1'b0, "awready lasts one cycle");
        check_equal(s_bvalid, 1'b1, "bvalid one cycle after write accept");
        check_equal(s_bresp, 2'b00, "write response");
    endtask

    task automatic axi_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data);
        @(negedge s_sysclk);
        s_araddr  = addr;
        s_arvalid = 1'b1;
        check_equal(s_arready, 1'b1, "arready while rvalid is low");
        @(negedge s_sysclk);
        s_arvalid = 1'b0;
        check_equal(s_rvalid, 1'b1, "rvalid one cycle after read accept");
        check_equal(s_rresp, 2'b00, "read response");
        data = s_rdata;
    endtask

    task automatic arm_slave(input logic cpol, input logic cpha, input logic pol,
                             input int cs, input int nchar);
        logic [NCS-1:0] onehot;
        onehot = NCS'(1) << cs;
        cur_cpol = cpol;
        cur_cpha = cpha;
        cur_pol = pol;
        sel_exp = pol ? onehot : ~onehot;
        mosi_seen.delete();
        rx_exp.delete();
        miso_q.delete();
        for (int i = 0; i < nchar; i++) begin
            miso_q.push_back(8'($random(seed)));
            rx_exp.push_back(miso_q[i]);
        end
        miso_byte = miso_q.pop_front();
        bit_idx = 0;
        sck_edges = 0;
        armed = 1'b1;
    endtask

    task automatic setup_frame(input int cs, input logic cpol, input logic cpha,
                               input logic pol, input logic [3:0] pm, input int nchar,
                               output logic [31:0] spcom);
        logic [31:0] mode;
        mode = '0;
        mode[CSMODE_CPOL] = cpol;
        mode[CSMODE_CPHA] = cpha;
        mode[CSMODE_POL] = pol;
        mode[CSMODE_PM_LO +: PM_W] = pm;
        spcom = '0;
        spcom[SPCOM_CS_LO +: 2] = 2'(cs);
        spcom[SPCOM_TRANLEN +: TRANLEN_W] = TRANLEN_W'(nchar - 1);
        axi_write(8'(CSMODE0) + 8'(4 * cs), mode, 4'hF);
        axi_write(SPMODE, 32'h0, 4'hF);  // core off so this SPCOM write starts no frame
        axi_write(SPCOM, spcom, 4'hF);
        axi_write(SPMODE, 32'h1 << SPMODE_EN, 4'hF);
        tx_exp.delete();
        arm_slave(cpol, cpha, pol, cs, nchar);
    endtask

    task automatic push_bytes(input int count);
        logic [7:0] b;
        for (int i = 0; i < count; i++) begin
            b = 8'($random(seed));
            tx_exp.push_back(b);
            axi_write(SPITF, {24'h0, b}, 4'hF);
        end
    endtask

    task automatic finish_frame(input logic don_irq);
        logic [31:0] rd;
        int          n;
        n = tx_exp.size();
        rd = '0;
        while (!rd[SPIE_DON]) begin
            axi_read(SPIE, rd);
        end
        armed = 1'b0;
        check_equal(interrupt, don_irq, "interrupt with DON set");
        check_equal(spi_sck, cur_cpol, "sck rest level after frame");
        check_equal(spi_sel, {NCS{~cur_pol}}, "chip selects after frame");
        check_equal(mosi_seen.size(), n, "characters seen on MOSI");
        for (int i = 0; i < n; i++) begin
            check_equal(mosi_seen[i], tx_exp[i], "MOSI byte");
        end
        axi_write(SPIE, 32'h1 << SPIE_DON, 4'hF); // write one clears DON
        check_equal(interrupt, 1'b0, "interrupt after DON clear");
        axi_read(SPIE, rd);
        check_equal(rd[SPIE_DON], 1'b0, "DON after clear");
        for (int i = 0; i < n; i++) begin
            axi_read(SPIRF, rd);
            check_equal(rd, {24'h0, rx_exp[i]}, "SPIRF byte");
        end
        axi_read(SPIRF, rd);
        check_equal(rd, 32'h0, "SPIRF read when empty");
        axi_read(SPIE, rd);
        check_equal(rd[SPIE_RNE], 1'b0, "RNE after draining");
    endtask

    initial begin
        logic [31:0] rd, v, spcom;
        logic [3:0]  pm;
        logic        cpol, cpha, pol, irq;
        int          cs, n, k;
        s_resetn  = 1'b0;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = 4'hF;
        s_wvalid  = 1'b0;
        s_bready  = 1'b1;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b1;
        repeat (16) @(negedge s_sysclk);
        s_resetn = 1'b1;
        check_equal(interrupt, 1'b0, "interrupt after reset");
        check_equal(spi_sck, 1'b0, "sck after reset");
        check_equal(spi_sel, {NCS{1'b1}}, "chip selects after reset");

        for (int i = 0; i < NCS; i++) begin
            v = $random(seed);
            axi_write(8'(CSMODE0) + 8'(4 * i), v, 4'hF);
            axi_read(8'(CSMODE0) + 8'(4 * i), rd);
            check_equal(rd, v, "CSMODE readback");
        end
        v = $random(seed);
        axi_write(SPIM, v, 4'hF);
        axi_read(SPIM, rd);
        check_equal(rd, v, "SPIM readback");
        axi_write(SPIM, ~v, 4'b0111);
        axi_read(SPIM, rd);
        check_equal(rd, v, "SPIM after partial strobe");

        // fill the TX FIFO to the top, then send it all as one frame
        setup_frame(0, 1'b0, 1'b0, 1'b0, 4'd0, FIFO_DEPTH, spcom);
        axi_write(SPIM, 32'h1 << SPIE_DON, 4'hF);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            push_bytes(1);
            axi_read(SPIE, rd);
            check_equal(rd[SPIE_TNF], i < FIFO_DEPTH - 1, "TNF while filling");
        end
        axi_write(SPCOM, spcom, 4'hF);
        finish_frame(1'b1);

        for (int f = 0; f < N_FRAMES; f++) begin
            cs = {$random(seed)} % NCS;
            n = 1 + {$random(seed)} % 12;
            cpol = 1'($random(seed));
            cpha = 1'($random(seed));
            pol = 1'($random(seed));
            irq = 1'($random(seed));
            pm = 4'({$random(seed)} % 4);
            setup_frame(cs, cpol, cpha, pol, pm, n, spcom);
            axi_write(SPIM, 32'(irq) << SPIE_DON, 4'hF);
            if (f % 5 == 4 && n > 1) begin
                k = n / 2;
                push_bytes(k);
                axi_write(SPCOM, spcom, 4'hF);
                while (mosi_seen.size() < k) begin
                    @(negedge s_sysclk);
                end
                v = sck_edges;
                repeat (40) @(negedge s_sysclk); // master starved in DATA_WAIT
                check_equal(sck_edges, v, "sck edges while TX FIFO empty");
                check_equal(spi_sel, sel_exp, "chip select held while starved");
                axi_read(SPIE, rd);
                check_equal(rd[SPIE_DON], 1'b0, "DON while starved");
                axi_write(SPCOM, spcom ^ 32'h0000_00FF, 4'hF);
                axi_read(SPCOM, rd);
                check_equal(rd, spcom, "SPCOM write during frame");
                push_bytes(n - k);
            end else begin
                push_bytes(n);
                axi_write(SPCOM, spcom, 4'hF);
            end
            finish_frame(irq);
        end

        if (err_cnt == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1, "%0d checks failed", err_cnt);
        end
    end

endmodule

// ==== hw/spi_top.sv ====
`timescale 1ns/1ps

module spi_top
    import spi_pkg::*;
#(
    parameter int NCS        = 4,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                s_sysclk,
    input  logic                s_resetn,
    input  logic [ADDR_W-1:0]   s_awaddr_i,
    input  logic                s_awvalid_i,
    output logic                s_awready_o,
    input  logic [DATA_W-1:0]   s_wdata_i,
    input  logic [DATA_W/8-1:0] s_wstrb_i,
    input  logic                s_wvalid_i,
    output logic                s_wready_o,
    output logic                s_bvalid_o,
    input  logic                s_bready_i,
    output logic [1:0]          s_bresp_o,
    input  logic [ADDR_W-1:0]   s_araddr_i,
    input  logic                s_arvalid_i,
    output logic                s_arready_o,
    output logic [DATA_W-1:0]   s_rdata_o,
    output logic                s_rvalid_o,
    input  logic                s_rready_i,
    output logic [1:0]          s_rresp_o,
    output logic                interrupt_o,
    output logic                spi_sck_o,
    output logic                spi_mosi_o,
    input  logic                spi_miso_i,
    output logic [NCS-1:0]      spi_sel_o
);

    logic                 tx_push, tx_full, tx_pop, tx_empty;
    logic                 rx_push, rx_full, rx_pop, rx_empty;
    logic [CHAR_W-1:0]    tx_wdata, tx_rdata, rx_wdata, rx_rdata;
    logic                 enable, frame_start, frame_busy, frame_done;
    logic                 cpol, cpha, cs_pol;
    logic [1:0]           cs_idx;
    logic [PM_W-1:0]      pm;
    logic [TRANLEN_W-1:0] tranlen;

    spi_regs #(.NCS(NCS), .FIFO_DEPTH(FIFO_DEPTH)) u_regs (
        .*,
        .tx_push_o     (tx_push),
        .tx_data_o     (tx_wdata),
        .tx_full_i     (tx_full),
        .rx_pop_o      (rx_pop),
        .rx_data_i     (rx_rdata),
        .rx_empty_i    (rx_empty),
        .enable_o      (enable),
        .frame_start_o (frame_start),
        .tranlen_o     (tranlen),
        .cs_idx_o      (cs_idx),
        .cpol_o        (cpol),
        .cpha_o        (cpha),
        .cs_pol_o      (cs_pol),
        .pm_o          (pm),
        .frame_busy_i  (frame_busy),
        .frame_done_i  (frame_done)
    );

    spi_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_tx_fifo (
        .*,
        .push_i  (tx_push),
        .data_i  (tx_wdata),
        .pop_i   (tx_pop),
        .data_o  (tx_rdata),
        .full_o  (tx_full),
        .empty_o (tx_empty)
    );

    spi_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_rx_fifo (
        .*,
        .push_i  (rx_push),
        .data_i  (rx_wdata),
        .pop_i   (rx_pop),
        .data_o  (rx_rdata),
        .full_o  (rx_full),
        .empty_o (rx_empty)
    );

    spi_master #(.NCS(NCS)) u_master (
        .*,
        .enable_i      (enable),
        .frame_start_i (frame_start),
        .tranlen_i     (tranlen),
        .cs_idx_i      (cs_idx),
        .cpol_i        (cpol),
        .cpha_i        (cpha),
        .cs_pol_i      (cs_pol),
        .pm_i          (pm),
        .frame_busy_o  (frame_busy),
        .frame_done_o  (frame_done),
        .tx_pop_o      (tx_pop),
        .tx_data_i     (tx_rdata),
        .tx_empty_i    (tx_empty),
        .rx_push_o     (rx_push),
        .rx_data_o     (rx_wdata),
        .rx_full_i     (rx_full)
    );

endmodule

// ==== hw/spi_regs.sv ====
`timescale 1ns/1ps

module spi_regs
    import spi_pkg::*;
#(
    parameter int NCS        = 4,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                 s_sysclk,
    input  logic                 s_resetn,
    input  logic [ADDR_W-1:0]    s_awaddr_i,
    input  logic                 s_awvalid_i,
    output logic                 s_awready_o,
    input  logic [DATA_W-1:0]    s_wdata_i,
    input  logic [DATA_W/8-1:0]  s_wstrb_i,
    input  logic                 s_wvalid_i,
    output logic                 s_wready_o,
    output logic                 s_bvalid_o,
    input  logic                 s_bready_i,
    output logic [1:0]           s_bresp_o,
    input  logic [ADDR_W-1:0]    s_araddr_i,
    input  logic                 s_arvalid_i,
    output logic                 s_arready_o,
    output logic [DATA_W-1:0]    s_rdata_o,
    output logic                 s_rvalid_o,
    input  logic                 s_rready_i,
    output logic [1:0]           s_rresp_o,
    output logic                 tx_push_o,
    output logic [CHAR_W-1:0]    tx_data_o,
    input  logic                 tx_full_i,
    output logic                 rx_pop_o,
    input  logic [CHAR_W-1:0]    rx_data_i,
    input  logic                 rx_empty_i,
    output logic                 enable_o,
    output logic                 frame_start_o,
    output logic [TRANLEN_W-1:0] tranlen_o,
    output logic [1:0]           cs_idx_o,
    output logic                 cpol_o,
    output logic                 cpha_o,
    output logic                 cs_pol_o,
    output logic [PM_W-1:0]      pm_o,
    input  logic                 frame_busy_i,
    input  logic                 frame_done_i,
    output logic                 interrupt_o
);

    logic [DATA_W-1:0] spmode_q, spie_q, spim_q, spcom_q;
    logic [DATA_W-1:0] csmode_q [NCS];
    logic [DATA_W-1:0] csmode_sel, rdata_q;
    logic              wr_en, wr_full, rd_en;
    logic [1:0]        wr_cs, rd_cs;
    reg_addr_e         wr_addr, rd_addr;

    assign wr_en   = s_awready_o && s_awvalid_i && s_wvalid_i;
    assign wr_full = wr_en && (s_wstrb_i == '1); // partial strobes are dropped
    assign rd_en   = s_arvalid_i && s_arready_o;
    assign wr_addr = reg_addr_e'(s_awaddr_i);
    assign rd_addr = reg_addr_e'(s_araddr_i);
    assign wr_cs   = s_awaddr_i[3:2];
    assign rd_cs   = s_araddr_i[3:2];

    assign s_wready_o  = s_awready_o;
    assign s_arready_o = !s_rvalid_o;
    assign s_bresp_o   = 2'b00;
    assign s_rresp_o   = 2'b00;
    assign s_rdata_o   = rdata_q;

    assign tx_push_o = wr_full && (wr_addr == SPITF) && enable_o && !tx_full_i;
    assign tx_data_o = s_wdata_i[CHAR_W-1:0];
    assign rx_pop_o  = rd_en && (rd_addr == SPIRF);

    assign csmode_sel  = (cs_idx_o < NCS) ? csmode_q[cs_idx_o] : CSMODE_DEF;
    assign enable_o    = spmode_q[SPMODE_EN];
    assign tranlen_o   = spcom_q[SPCOM_TRANLEN +: TRANLEN_W];
    assign cs_idx_o    = spcom_q[SPCOM_CS_LO +: 2];
    assign cpol_o      = csmode_sel[CSMODE_CPOL];
    assign cpha_o      = csmode_sel[CSMODE_CPHA];
    assign cs_pol_o    = csmode_sel[CSMODE_POL];
    assign pm_o        = csmode_sel[CSMODE_PM_LO +: PM_W];
    assign interrupt_o = |(spie_q & spim_q);

    always_ff @(posedge s_sysclk or negedge s_resetn) begin
        if (!s_resetn) begin
            s_awready_o <= 1'b0;
            s_bvalid_o  <= 1'b0;
            s_rvalid_o  <= 1'b0;
        end else begin
            // one-cycle ready once both halves of the write are present
            s_awready_o <= s_awvalid_i && s_wvalid_i && !s_awready_o && !s_bvalid_o;
            if (wr_en) begin
                s_bvalid_o <= 1'b1;
            end else if (s_bready_i) begin
                s_bvalid_o <= 1'b0;
            end
            if (rd_en) begin
                s_rvalid_o <= 1'b1;
            end else if (s_rready_i) begin
                s_rvalid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge s_sysclk or negedge s_resetn) begin
        if (!s_resetn) begin
            spmode_q      <= SPMODE_DEF;
            spie_q        <= SPIE_DEF;
            spim_q        <= '0;
            spcom_q       <= '0;
            frame_start_o <= 1'b0;
            for (int i = 0; i < NCS; i++) begin
                csmode_q[i] <= CSMODE_DEF;
            end
        end else begin
            frame_start_o    <= 1'b0;
            spie_q[SPIE_RNE] <= !rx_empty_i;
            spie_q[SPIE_TNF] <= !tx_full_i;
            if (frame_done_i) begin
                spie_q[SPIE_DON] <= 1'b1;
            end else if (wr_full && (wr_addr == SPIE) && s_wdata_i[SPIE_DON]) begin
                spie_q[SPIE_DON] <= 1'b0; // write one to clear
            end
            if (wr_full) begin
                case (wr_addr)
                    SPMODE: spmode_q <= s_wdata_i;
                    SPIM:   spim_q <= s_wdata_i;
                    SPCOM: begin
                        if (!frame_busy_i) begin
                            spcom_q       <= s_wdata_i;
                            frame_start_o <= enable_o;
                        end
                    end
                    CSMODE0, CSMODE1, CSMODE2, CSMODE3: begin
                        if (wr_cs < NCS) begin
                            csmode_q[wr_cs] <= s_wdata_i;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge s_sysclk) begin
        if (rd_en) begin
            case (rd_addr)
                SPMODE:  rdata_q <= spmode_q;
                SPIE:    rdata_q <= spie_q;
                SPIM:    rdata_q <= spim_q;
                SPCOM:   rdata_q <= spcom_q;
                SPIRF:   rdata_q <= rx_empty_i ? '0 : DATA_W'(rx_data_i);
                CSMODE0, CSMODE1, CSMODE2, CSMODE3: begin
                    rdata_q <= (rd_cs < NCS) ? csmode_q[rd_cs] : '0;
                end
                default: rdata_q <= '0;
            endcase
        end
    end

    initial begin
        assert (NCS >= 1 && NCS <= 4 && FIFO_DEPTH >= 2 && (FIFO_DEPTH & (FIFO_DEPTH - 1)) == 0)
            else $fatal(1, "spi_regs: NCS or FIFO_DEPTH out of range");
    end

    // response must leave before the next write is taken
    assert property (@(posedge s_sysclk) disable iff (!s_resetn) !(s_bvalid_o && wr_en));

endmodule

// ==== hw/spi_master.sv ====
`timescale 1ns/1ps

module spi_master
    import spi_pkg::*;
#(
    parameter int NCS = 4
) (
    input  logic                 s_sysclk,
    input  logic                 s_resetn,
    input  logic                 enable_i,
    input  logic                 frame_start_i,
    input  logic [TRANLEN_W-1:0] tranlen_i,
    input  logic [1:0]           cs_idx_i,
    input  logic                 cpol_i,
    input  logic                 cpha_i,
    input  logic                 cs_pol_i,
    input  logic [PM_W-1:0]      pm_i,
    output logic                 frame_busy_o,
    output logic                 frame_done_o,
    output logic                 tx_pop_o,
    input  logic [CHAR_W-1:0]    tx_data_i,
    input  logic                 tx_empty_i,
    output logic                 rx_push_o,
    output logic [CHAR_W-1:0]    rx_data_o,
    input  logic                 rx_full_i,
    output logic                 spi_sck_o,
    output logic                 spi_mosi_o,
    output logic [NCS-1:0]       spi_sel_o,
    input  logic                 spi_miso_i
);

    localparam int EDGE_W = $clog2(2 * CHAR_W);

    frame_state_e         state_q;
    logic [PM_W-1:0]      div_cnt;
    logic [EDGE_W-1:0]    edge_cnt; // even is leading, odd is trailing
    logic [TRANLEN_W-1:0] char_cnt;
    logic [CHAR_W-1:0]    tx_sr, rx_sr;
    logic                 sck_q, mosi_q, pol_q;
    logic [NCS-1:0]       sel_q, cs_onehot;
    logic                 tick, leading, last_edge, shift_edge, sample_edge;

    assign tick        = (state_q == SHIFT) && (div_cnt == pm_i);
    assign leading     = !edge_cnt[0];
    assign last_edge   = tick && (edge_cnt == EDGE_W'(2 * CHAR_W - 1));
    assign shift_edge  = tick && (leading == cpha_i);
    assign sample_edge = tick && (leading != cpha_i);
    assign cs_onehot   = NCS'(1) << cs_idx_i;

    assign frame_busy_o = (state_q != IDLE);
    assign frame_done_o = (state_q == DONE);
    assign tx_pop_o     = enable_i && (state_q == DATA_WAIT) && !tx_empty_i && !rx_full_i;
    assign rx_push_o    = last_edge;
    // with cpha 1 the final bit is sampled on the last edge itself
    assign rx_data_o    = cpha_i ? {rx_sr[CHAR_W-2:0], spi_miso_i} : rx_sr;
    assign spi_sck_o    = sck_q;
    assign spi_mosi_o   = mosi_q;
    assign spi_sel_o    = sel_q;

    always_ff @(posedge s_sysclk or negedge s_resetn) begin
        if (!s_resetn) begin
            state_q  <= IDLE;
            div_cnt  <= '0;
            edge_cnt <= '0;
            char_cnt <= '0;
            sck_q    <= 1'b0;
            pol_q    <= 1'b0;
            sel_q    <= '1;
        end else if (!enable_i) begin
            state_q <= IDLE;
            sck_q   <= cpol_i;
            sel_q   <= {NCS{~pol_q}};
        end else begin
            case (state_q)
                IDLE: begin
                    sck_q <= cpol_i;
                    if (frame_start_i) begin
                        pol_q    <= cs_pol_i;
                        sel_q    <= cs_pol_i ? cs_onehot : ~cs_onehot;
                        char_cnt <= '0;
                        state_q  <= DATA_WAIT;
                    end
                end
                DATA_WAIT: begin
                    sck_q <= cpol_i; // idle level while starved
                    if (tx_pop_o) begin
                        div_cnt  <= '0;
                        edge_cnt <= '0;
                        state_q  <= SHIFT;
                    end
                end
                SHIFT: begin
                    if (tick) begin
                        div_cnt  <= '0;
                        edge_cnt <= edge_cnt + 1'b1;
                        sck_q    <= ~sck_q;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                    if (last_edge) begin
                        char_cnt <= char_cnt + 1'b1;
                        state_q  <= (char_cnt == tranlen_i) ? DONE : DATA_WAIT;
                    end
                end
                DONE: begin
                    sck_q   <= cpol_i;
                    sel_q   <= {NCS{~pol_q}};
                    state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge s_sysclk or negedge s_resetn) begin
        if (!s_resetn) begin
            mosi_q <= 1'b0;
        end else if (tx_pop_o && !cpha_i) begin
            mosi_q <= tx_data_i[CHAR_W-1]; // msb set up before first edge
        end else if (shift_edge) begin
            mosi_q <= tx_sr[CHAR_W-1];
        end
    end

    always_ff @(posedge s_sysclk) begin
        if (tx_pop_o) begin
            tx_sr <= cpha_i ? tx_data_i : {tx_data_i[CHAR_W-2:0], 1'b0};
        end else if (shift_edge) begin
            tx_sr <= {tx_sr[CHAR_W-2:0], 1'b0};
        end
        if (sample_edge) begin
            rx_sr <= {rx_sr[CHAR_W-2:0], spi_miso_i};
        end
    end

    // sixteen toggles per character bring sck back to idle
    assert property (@(posedge s_sysclk) disable iff (!s_resetn)
        state_q != SHIFT && $stable(cpol_i) |-> spi_sck_o == cpol_i);
    assert property (@(posedge s_sysclk) disable iff (!s_resetn)
        $onehot0(spi_sel_o ^ {NCS{~pol_q}}));

endmodule

// ==== hw/spi_fifo.sv ====
`timescale 1ns/1ps

module spi_fifo
    import spi_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic              s_sysclk,
    input  logic              s_resetn,
    input  logic              push_i,
    input  logic [CHAR_W-1:0] data_i,
    input  logic              pop_i,
    output logic [CHAR_W-1:0] data_o,
    output logic              full_o,
    output logic              empty_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    logic [CHAR_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr, rd_ptr;
    logic [PTR_W:0]    count;
    logic              do_push, do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;
    assign full_o  = (count == (PTR_W+1)'(FIFO_DEPTH));
    assign empty_o = (count == '0);
    assign data_o  = mem[rd_ptr]; // head is visible without a pop

    always_ff @(posedge s_sysclk or negedge s_resetn) begin
        if (!s_resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge s_sysclk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_i;
        end
    end

    // rejected requests leave pointers and flags as they were
    assert property (@(posedge s_sysclk) disable iff (!s_resetn)
        push_i && full_o && !pop_i |=> full_o && wr_ptr == $past(wr_ptr));
    assert property (@(posedge s_sysclk) disable iff (!s_resetn)
        pop_i && empty_o && !push_i |=> empty_o && rd_ptr == $past(rd_ptr));

endmodule

// ==== hw/spi_pkg.sv ====
package spi_pkg;

    localparam int ADDR_W    = 8;
    localparam int DATA_W    = 32;
    localparam int CHAR_W    = 8;
    localparam int TRANLEN_W = 16;
    localparam int PM_W      = 4;

    // byte offsets of the register map
    typedef enum logic [ADDR_W-1:0] {
        SPMODE  = 8'h00,
        SPIE    = 8'h04,
        SPIM    = 8'h08,
        SPCOM   = 8'h0C,
        SPITF   = 8'h10,
        SPIRF   = 8'h14,
        CSMODE0 = 8'h20,
        CSMODE1 = 8'h24,
        CSMODE2 = 8'h28,
        CSMODE3 = 8'h2C
    } reg_addr_e;

    typedef enum logic [1:0] {
        IDLE,
        DATA_WAIT,
        SHIFT,
        DONE
    } frame_state_e;

    localparam int SPMODE_EN     = 31;
    localparam int SPIE_DON      = 14;
    localparam int SPIE_RNE      = 9;
    localparam int SPIE_TNF      = 8;
    localparam int CSMODE_CPOL   = 29;
    localparam int CSMODE_CPHA   = 28;
    localparam int CSMODE_PM_LO  = 24; // pm is 27:24
    localparam int CSMODE_POL    = 20; // 1 = active high select
    localparam int SPCOM_CS_LO   = 30; // cs is 31:30
    localparam int SPCOM_TRANLEN = 0;  // length field 15:0, chars minus one

    localparam logic [DATA_W-1:0] SPMODE_DEF = '0;
    localparam logic [DATA_W-1:0] CSMODE_DEF = '0;
    localparam logic [DATA_W-1:0] SPIE_DEF   = DATA_W'(1) << SPIE_TNF;

endpackage
